/* hw/activity_monitor.sv */
`timescale 1ns/1ps
`include "revo_link_config.svh"

module activity_monitor import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	marker_if.sink marker,
	output logic activity
);

	logic [`ACTIVITY_WINDOW_LOG2-1:0] window_count;
	logic window_end;
	logic seen;

	// Last cycle of the window
	assign window_end = &window_count;

	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			window_count <= '0;
			seen <= 1'b0;
			activity <= 1'b0;
		end else begin
			window_count <= window_count + 1'b1;
			if (window_end) begin
				activity <= seen;
				// Onset in the wrap cycle belongs to the next window
				seen <= marker.onset;
			end else if (marker.onset) begin
				seen <= 1'b1;
			end
		end
	end

endmodule

/* hw/marker_detector.sv */
`timescale 1ns/1ps
`include "revo_link_config.svh"

module marker_detector import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	input stream_word_t stream,
	marker_if.source marker
);

	stream_word_t stream_q;
	stream_word_t prev_word;
	stream_word_t rise;
	phase_t first_rise;

	// Samples that are high now and were low one word earlier
	assign rise = stream_q & ~prev_word;

	// Earliest rising sample wins
	always_comb begin
		first_rise = '0;
		for (int i = `REVO_WIDTH - 1; i >= 0; i--) begin
			if (rise[i]) begin
				first_rise = phase_t'(i);
			end
		end
	end

	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			stream_q <= '0;
			prev_word <= '0;
			marker.pulse <= '0;
			marker.level <= 1'b0;
			marker.onset <= 1'b0;
			marker.phase <= '0;
		end else begin
			stream_q <= stream;
			prev_word <= stream_q;
			marker.pulse <= rise;
			marker.level <= |stream_q;
			// Registered level still holds the previous word here
			marker.onset <= (|stream_q) & ~marker.level;
			marker.phase <= first_rise;
		end
	end

endmodule

/* hw/marker_if.sv */
`timescale 1ns/1ps

interface marker_if import revo_link_pkg::*; ();

	// One bit per sample that rose against the previous word
	stream_word_t pulse;

	// Some sample of the word was high
	logic level;

	// Level rose this cycle
	logic onset;

	// Lowest set pulse bit
	phase_t phase;

	modport source (output pulse, output level, output onset, output phase);

	modport sink (input pulse, input level, input onset, input phase);

endinterface

/* hw/phase_aligner.sv */
`timescale 1ns/1ps

module phase_aligner import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	marker_if.sink marker,
	output phase_t phase_select,
	output stream_word_t phase_pattern,
	output logic phase_locked,
	output logic [7:0] phase_errors
);

	logic thermometer;
	logic clean;
	logic mismatch;

	// --------------------
	// Clean marker test
	// --------------------

	// Pulse must be all ones from its phase up to the latest sample
	assign thermometer = (marker.pulse == (stream_word_t'('1) << marker.phase));
	assign clean = marker.onset & thermometer;

	// Only counted once a phase has been taken
	assign mismatch = phase_locked & clean & (marker.phase != phase_select);

	// --------------------
	// Lock and error count
	// --------------------

	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			phase_select <= '0;
			phase_pattern <= '0;
			phase_locked <= 1'b0;
		end else if (!phase_locked && clean) begin
			phase_select <= marker.phase;
			phase_pattern <= marker.pulse;
			phase_locked <= 1'b1;
		end
	end

	// Saturates at 255
	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			phase_errors <= '0;
		end else if (mismatch && phase_errors != 8'hff) begin
			phase_errors <= phase_errors + 8'd1;
		end
	end

endmodule

/* hw/revo_link_config.svh */
`ifndef REVO_LINK_CONFIG_SVH
`define REVO_LINK_CONFIG_SVH

// --------------------
// Link word sizes
// --------------------

// Samples per clock127 word from the 4x sampler
`define REVO_WIDTH 4

// Bits per serialized output symbol
`define SYMBOL_WIDTH 8

// --------------------
// Activity reporting
// --------------------

// Window length is 2**ACTIVITY_WINDOW_LOG2 cycles
`define ACTIVITY_WINDOW_LOG2 8

`endif

/* hw/revo_link_pkg.sv */
`include "revo_link_config.svh"

package revo_link_pkg;

	// One deserialized word, bit 0 is the earliest sample
	typedef logic [`REVO_WIDTH-1:0] stream_word_t;

	// Sample index inside a word
	typedef logic [$clog2(`REVO_WIDTH)-1:0] phase_t;

	// One output symbol
	typedef logic [`SYMBOL_WIDTH-1:0] symbol_t;

	// --------------------
	// Symbol constants
	// --------------------

	// Idle frames
	localparam symbol_t SYMBOL_NULL = '0;

	// Marker frames, alternating bit pairs
	localparam symbol_t SYMBOL_MARKER = symbol_t'(8'b11001100);

endpackage

/* hw/revo_link_top.sv */
`timescale 1ns/1ps

module revo_link_top import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	input stream_word_t revo_stream,
	output logic trigger,
	output logic marker_level,
	output logic serial_out,
	output logic frame_start,
	output phase_t phase_select,
	output stream_word_t phase_pattern,
	output logic phase_locked,
	output logic [7:0] phase_errors,
	output logic activity
);

	logic marker_strobe;
	symbol_t symbol;

	// Detected marker shared by three consumers
	marker_if marker_bus ();

	// --------------------
	// Detection
	// --------------------

	marker_detector detector0 (
		.clock127(clock127),
		.reset(reset),
		.stream(revo_stream),
		.marker(marker_bus.source)
	);

	// --------------------
	// Consumers
	// --------------------

	phase_aligner aligner0 (
		.clock127(clock127),
		.reset(reset),
		.marker(marker_bus.sink),
		.phase_select(phase_select),
		.phase_pattern(phase_pattern),
		.phase_locked(phase_locked),
		.phase_errors(phase_errors)
	);

	trigger_encoder encoder0 (
		.clock127(clock127),
		.reset(reset),
		.marker(marker_bus.sink),
		.trigger(trigger),
		.marker_level(marker_level),
		.marker_strobe(marker_strobe),
		.symbol(symbol)
	);

	// Frames the encoder's symbol onto serial_out
	symbol_serializer serializer0 (
		.clock127(clock127),
		.reset(reset),
		.marker_strobe(marker_strobe),
		.symbol(symbol),
		.serial_out(serial_out),
		.frame_start(frame_start)
	);

	activity_monitor monitor0 (
		.clock127(clock127),
		.reset(reset),
		.marker(marker_bus.sink),
		.activity(activity)
	);

endmodule

/* hw/symbol_serializer.sv */
`timescale 1ns/1ps
`include "revo_link_config.svh"

module symbol_serializer import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	input logic marker_strobe,
	input symbol_t symbol,
	output logic serial_out,
	output logic frame_start
);

	logic [2:0] frame_count;
	logic boundary;
	logic pending;
	symbol_t held_symbol;
	symbol_t next_symbol;
	logic load_marker;
	symbol_t shift_reg;

	// Load happens on the edge that wraps the frame counter
	assign boundary = (frame_count == 3'd7);

	// A strobe in the boundary cycle still makes this frame
	assign load_marker = pending | marker_strobe;
	assign next_symbol = marker_strobe ? symbol : held_symbol;

	// --------------------
	// Framing
	// --------------------

	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			frame_count <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_count <= frame_count + 3'd1;
			frame_start <= boundary;
		end
	end

	// --------------------
	// Pending marker
	// --------------------

	// Repeated strobes before the load merge into one marker
	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (boundary) begin
			pending <= 1'b0;
		end else if (marker_strobe) begin
			pending <= 1'b1;
		end
	end

	always_ff @(posedge clock127) begin
		if (marker_strobe) begin
			held_symbol <= symbol;
		end
	end

	// MSB first shift-out
	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			shift_reg <= SYMBOL_NULL;
		end else if (boundary) begin
			shift_reg <= load_marker ? next_symbol : SYMBOL_NULL;
		end else begin
			shift_reg <= shift_reg << 1;
		end
	end

	assign serial_out = shift_reg[`SYMBOL_WIDTH-1];

endmodule

/* hw/trigger_encoder.sv */
`timescale 1ns/1ps

module trigger_encoder import revo_link_pkg::*; (
	input logic clock127,
	input logic reset,
	marker_if.sink marker,
	output logic trigger,
	output logic marker_level,
	output logic marker_strobe,
	output symbol_t symbol
);

	logic onset_q;

	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			onset_q <= 1'b0;
			marker_level <= 1'b0;
		end else begin
			onset_q <= marker.onset;
			// Acknowledge level follows the marker
			marker_level <= marker.level;
		end
	end

	// One cycle per marker onset
	assign trigger = onset_q;

	// Same strobe toward the serializer
	assign marker_strobe = onset_q;

	// Symbol offered only while the strobe is high
	assign symbol = onset_q ? SYMBOL_MARKER : SYMBOL_NULL;

endmodule

/* revo_link.f */
+incdir+hw
hw/revo_link_pkg.sv
hw/marker_if.sv
hw/marker_detector.sv
hw/phase_aligner.sv
hw/trigger_encoder.sv
hw/symbol_serializer.sv
hw/activity_monitor.sv
hw/revo_link_top.sv
verif/revo_link_checker.sv
verif/revo_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with the design
verilator --binary --timing --assert --top-module revo_link_tb \
	-f revo_link.f -o revo_link_sim

# Run and keep the output for the result search
output=$(./obj_dir/revo_link_sim)
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi

/* verif/revo_link_checker.sv */
`timescale 1ns/1ps

module revo_link_checker (
	input logic clock127,
	input logic reset,
	input logic trigger,
	input logic frame_start,
	input logic phase_locked,
	input logic [7:0] phase_errors
);

	logic [3:0] since_frame;
	logic frame_seen;

	// Cycles since the last frame_start, saturating
	always_ff @(posedge clock127 or posedge reset) begin
		if (reset) begin
			since_frame <= '0;
			frame_seen <= 1'b0;
		end else if (frame_start) begin
			since_frame <= 4'd1;
			frame_seen <= 1'b1;
		end else if (since_frame != 4'hf) begin
			since_frame <= since_frame + 4'd1;
		end
	end

	trigger_single: assert property (@(posedge clock127) disable iff (reset)
		trigger |=> !trigger)
		else $error("trigger stayed high for more than one cycle");

	frame_period: assert property (@(posedge clock127) disable iff (reset)
		frame_seen |-> (frame_start == (since_frame == 4'd8)))
		else $error("frame_start did not recur every 8 cycles");

	lock_held: assert property (@(posedge clock127) disable iff (reset)
		$past(phase_locked) |-> phase_locked)
		else $error("phase_locked fell outside reset");

	errors_monotonic: assert property (@(posedge clock127) disable iff (reset)
		phase_errors >= $past(phase_errors))
		else $error("phase_errors decreased");

endmodule

/* verif/revo_link_tb.sv */
`timescale 1ns/1ps
`include "revo_link_config.svh"

module revo_link_tb import revo_link_pkg::*; ();

	localparam int FIRST_BURSTS = 24;
	localparam int SECOND_BURSTS = 10;
	localparam int LONG_GAP = 300;
	localparam int TAIL_WORDS = 40;
	localparam int MAX_WORDS = (FIRST_BURSTS + SECOND_BURSTS) * 23
		+ LONG_GAP + 2 * TAIL_WORDS + 20;
	localparam int WINDOW = 1 << `ACTIVITY_WINDOW_LOG2;

	logic clock127, reset, trigger, marker_level, serial_out, frame_start, phase_locked, activity;
	stream_word_t revo_stream, phase_pattern;
	phase_t phase_select;
	logic [7:0] phase_errors;

	logic [31:0] lfsr_state;
	stream_word_t hist[$];
	bit window_onset [0:15];
	int err_count [1:6];
	int check_count, burst_count, exp_triggers, dut_triggers, dut_marker_frames, dut_n;
	int p, j, m, m_load, m_errors, total;
	bit second_half, m_locked, m_pend, exp_trigger;
	phase_t m_phase;
	stream_word_t m_pattern;
	symbol_t m_frame, dut_bits;
	string test_names [1:6];

	revo_link_top dut0 (.*);

	bind revo_link_top revo_link_checker checker0 (
		.clock127(clock127), .reset(reset), .trigger(trigger),
		.frame_start(frame_start), .phase_locked(phase_locked), .phase_errors(phase_errors)
	);

	initial begin
		clock127 = 1'b0;
		forever #5 clock127 = ~clock127;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	// --------------------
	// Reference model
	// --------------------

	function automatic stream_word_t word_at(input int k);
		return (k >= 0 && k < hist.size()) ? hist[k] : stream_word_t'(0);
	endfunction

	function automatic bit onset_of(input int k);
		return (|word_at(k)) && !(|word_at(k - 1));
	endfunction

	function automatic stream_word_t pulse_of(input int k);
		return word_at(k) & ~word_at(k - 1);
	endfunction

	function automatic phase_t phase_of(input int k);
		stream_word_t pw;
		phase_t ph;
		pw = pulse_of(k);
		ph = '0;
		for (int b = `REVO_WIDTH - 1; b >= 0; b--) begin
			if (pw[b]) ph = phase_t'(b);
		end
		return ph;
	endfunction

	// Clean markers are thermometers from the top
	function automatic bit clean_of(input int k);
		return onset_of(k) && (pulse_of(k) inside {4'b1111, 4'b1110, 4'b1100, 4'b1000});
	endfunction

	task automatic report_error(input int test, input string msg);
		err_count[test]++;
		$display("Error at %0t ns: test %0d, %s", $time, test, msg);
	endtask

	task automatic compare_value(input int test, input string name, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			report_error(test, $sformatf("%s is %0d, expected %0d", name, got, exp));
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------

	task automatic drive_word(input stream_word_t w);
		@(posedge clock127);
		revo_stream <= w;
		hist.push_back(w);
	endtask

	task automatic drive_burst();
		int start, len, gap;
		draw_bits(2, start);
		draw_bits(2, len);
		draw_bits(3, gap);
		drive_word(stream_word_t'(4'hf) << start);
		repeat (len) drive_word(4'hf);
		repeat (12 + gap) drive_word(4'h0);
		burst_count++;
	endtask

	task automatic apply_reset();
		@(posedge clock127);
		reset <= 1'b1;
		hist.delete();
		repeat (5) @(posedge clock127);
		reset <= 1'b0;
	endtask

	// Outputs are compared in the middle of each cycle
	always @(negedge clock127) begin
		if (reset) begin
			compare_value(6, "trigger in reset", trigger, 0);
			compare_value(6, "serial_out in reset", serial_out, 0);
			compare_value(6, "frame_start in reset", frame_start, 0);
			compare_value(6, "marker_level in reset", marker_level, 0);
			compare_value(6, "phase outputs in reset",
				int'(phase_locked) + int'(phase_select) + int'(phase_pattern), 0);
			compare_value(6, "phase_errors in reset", phase_errors, 0);
			compare_value(6, "activity in reset", activity, 0);
			m_locked = 0;
			m_phase = '0;
			m_pattern = '0;
			m_errors = 0;
			m_pend = 0;
			m_load = -1;
			m_frame = SYMBOL_NULL;
			dut_n = 8;
			window_onset = '{default: 0};
		end else begin
			p = hist.size() - 1;
			j = p - 3;
			if (j >= 0 && clean_of(j)) begin
				if (!m_locked) begin
					m_locked = 1;
					m_phase = phase_of(j);
					m_pattern = pulse_of(j);
				end else if (phase_of(j) != m_phase && m_errors < 255) begin
					m_errors++;
				end
			end
			exp_trigger = onset_of(j);
			if (exp_trigger) window_onset[(j + 4) / WINDOW] = 1;
			m = (p + 1) / WINDOW;
			if (p >= 0 && p % 8 == 7) begin
				m_frame = m_pend ? SYMBOL_MARKER : SYMBOL_NULL;
				m_load = p;
				m_pend = 0;
			end
			if (exp_trigger) begin
				m_pend = 1;
				exp_triggers++;
			end
			compare_value(1, "trigger", trigger, int'(exp_trigger));
			compare_value(1, "marker_level", marker_level, int'(|word_at(j)));
			compare_value(second_half ? 6 : 2, "phase_locked", phase_locked, int'(m_locked));
			compare_value(second_half ? 6 : 2, "phase_select", phase_select, m_phase);
			compare_value(second_half ? 6 : 2, "phase_pattern", phase_pattern, m_pattern);
			compare_value(3, "phase_errors", phase_errors, m_errors);
			compare_value(4, "frame_start", frame_start, int'(p >= 0 && p % 8 == 7));
			compare_value(4, "serial_out", serial_out,
				(m_load >= 0) ? int'(m_frame[7 - (p - m_load)]) : 0);
			compare_value(5, "activity", activity, (m >= 1) ? int'(window_onset[m - 1]) : 0);
			if (trigger) dut_triggers++;
			// Reassemble each frame from the DUT
			if (frame_start) dut_n = 0;
			if (dut_n < 8) begin
				dut_bits = {dut_bits[6:0], serial_out};
				dut_n++;
				if (dut_n == 8 && dut_bits == SYMBOL_MARKER) dut_marker_frames++;
			end
		end
	end

	initial begin
		#(MAX_WORDS * 10 + 5000);
		$display("Watchdog expired: the run did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		test_names = '{"trigger and level", "phase lock", "phase errors",
			"serial frames", "activity", "mid-run reset"};
		err_count = '{default: 0};
		lfsr_state = 32'h50a6;
		reset = 1'b1;
		revo_stream = '0;
		repeat (5) @(posedge clock127);
		reset <= 1'b0;
		for (int i = 0; i < FIRST_BURSTS; i++) begin
			drive_burst();
			if (i == 5) repeat (LONG_GAP) drive_word(4'h0);
		end
		repeat (TAIL_WORDS) drive_word(4'h0);
		second_half = 1;
		apply_reset();
		for (int i = 0; i < SECOND_BURSTS; i++) drive_burst();
		repeat (TAIL_WORDS) drive_word(4'h0);
		// Last driven word gets its comparison before the summary
		@(negedge clock127);
		#1;
		if (dut_marker_frames != exp_triggers) report_error(4, "marker frame count mismatch");
		if (dut_triggers != burst_count) report_error(1, "trigger count differs from bursts");
		total = 0;
		for (int t = 1; t <= 6; t++) begin
			$display("Test %0d %s: %s, %0d errors", t, test_names[t],
				(err_count[t] == 0) ? "ok" : "failed", err_count[t]);
			total += err_count[t];
		end
		$display("Checks %0d, errors %0d, bursts %0d", check_count, total, burst_count);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
